//--- src/demodPkg.sv
package demodPkg;

    // Datapath widths
    localparam int sampleWidth = 18;               // Every sample path
    localparam int detWidth = 8;                   // Freq and phase values
    localparam int magWidth = 9;                   // Detector magnitude
    localparam int coefWidth = 16;                 // Alpha and threshold
    localparam int productWidth = 2 * sampleWidth; // Full 18x18 product

    // Left shifts that place narrow values at the top of a sample
    localparam int detShift = sampleWidth - detWidth;
    localparam int magShift = sampleWidth - magWidth;

    // Unity gain for the exponential average
    localparam logic [sampleWidth-1:0] alphaOne = 18'h20000;

    typedef logic signed [sampleWidth-1:0] sample_t;
    typedef logic signed [detWidth-1:0]    detector_t;
    typedef logic        [magWidth-1:0]    mag_t;
    typedef logic        [coefWidth-1:0]   coef_t;

    // Register bus
    typedef logic [11:0] regAddr_t;
    typedef logic [31:0] regData_t;
    typedef logic [3:0]  byteWrite_t;              // One strobe per byte lane

    localparam logic [7:0] demodSpaceBase = 8'h10; // Compared with addr[11:4]

    // Register offsets within demod space
    localparam logic [3:0] regMode      = 4'd0;
    localparam logic [3:0] regDacSelect = 4'd1;
    localparam logic [3:0] regFalseLock = 4'd2;
    localparam logic [3:0] regStatus    = 4'd3;    // Read only

    typedef enum logic [2:0] {
        modeAm    = 3'd0,
        modeFm    = 3'd1,
        modeBpsk  = 3'd2,
        modeQpsk  = 3'd3,
        modeOqpsk = 3'd4
    } demodMode_t;

    // Unlisted codes show ddc I
    typedef enum logic [3:0] {
        dacI       = 4'd0,
        dacQ       = 4'd1,
        dacISym    = 4'd2,
        dacQSym    = 4'd3,
        dacFreq    = 4'd4,
        dacPhase   = 4'd5,
        dacMag     = 4'd6,
        dacAvgFreq = 4'd10
    } dacSource_t;

    // Sample pair with its rate strobe
    typedef struct packed {
        sample_t i;
        sample_t q;
        logic    sync;
    } iqStrobe_t;

    typedef struct packed {
        detector_t freq;
        detector_t phase;
        mag_t      mag;
    } detectorOut_t;

    typedef struct packed {
        sample_t data;
        logic    sync;
    } dacOut_t;

    // Everything a monitor output can show
    typedef struct packed {
        iqStrobe_t    ddc;
        iqStrobe_t    sym;
        detectorOut_t det;
        sample_t      avgFreq;
    } monitorTaps_t;

endpackage

//--- src/demodRegs.sv
`timescale 1ns/1ps

module demodRegs (
    input  logic                 clk,
    input  logic                 arstN,
    input  demodPkg::regAddr_t   addr,
    input  demodPkg::regData_t   din,
    input  demodPkg::byteWrite_t wr,
    output demodPkg::regData_t   dout,
    input  logic                 highFreqOffset,
    output demodPkg::demodMode_t mode,
    output demodPkg::dacSource_t dacSel [3],
    output demodPkg::coef_t      falseLockAlpha,
    output demodPkg::coef_t      falseLockThreshold
);
    import demodPkg::*;

    logic       demodSpace;
    logic [3:0] regOffset;

    assign demodSpace = (addr[11:4] == demodSpaceBase); // Block select
    assign regOffset  = addr[3:0];                      // Register within block

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mode               <= modeAm;
            dacSel[0]          <= dacI;
            dacSel[1]          <= dacI;
            dacSel[2]          <= dacI;
            falseLockAlpha     <= '0;
            falseLockThreshold <= '0;
        end else if (demodSpace) begin
            case (regOffset)
                regMode: begin
                    if (wr[0]) begin
                        mode <= demodMode_t'(din[2:0]);
                    end
                end
                regDacSelect: begin
                    if (wr[0]) begin
                        dacSel[0] <= dacSource_t'(din[3:0]);   // Lane 0
                    end
                    if (wr[1]) begin
                        dacSel[1] <= dacSource_t'(din[11:8]);  // Lane 1
                    end
                    if (wr[2]) begin
                        dacSel[2] <= dacSource_t'(din[19:16]); // Lane 2
                    end
                end
                regFalseLock: begin
                    if (wr[0]) begin
                        falseLockAlpha[7:0] <= din[7:0];
                    end
                    if (wr[1]) begin
                        falseLockAlpha[15:8] <= din[15:8];
                    end
                    if (wr[2]) begin
                        falseLockThreshold[7:0] <= din[23:16];
                    end
                    if (wr[3]) begin
                        falseLockThreshold[15:8] <= din[31:24];
                    end
                end
                default: ;                                      // Status is read only
            endcase
        end
    end

    always_comb begin
        dout = '0;                                 // Zero outside demod space
        if (demodSpace) begin
            case (regOffset)
                regMode:      dout[2:0] = mode;
                regDacSelect: begin
                    dout[3:0]   = dacSel[0];
                    dout[11:8]  = dacSel[1];
                    dout[19:16] = dacSel[2];
                end
                regFalseLock: dout = {falseLockThreshold, falseLockAlpha};
                regStatus:    dout[0] = highFreqOffset;
                default:      dout = '0;
            endcase
        end
    end

    // Mode register only ever takes legal codes
    modeLegal: assert property (@(posedge clk) disable iff (!arstN)
        mode inside {modeAm, modeFm, modeBpsk, modeQpsk, modeOqpsk});

endmodule

//--- src/falseLockDetector.sv
`timescale 1ns/1ps

module falseLockDetector (
    input  logic              clk,
    input  logic              arstN,
    input  logic              ddcSync,
    input  demodPkg::detector_t freq,
    input  demodPkg::coef_t   falseLockAlpha,
    input  demodPkg::coef_t   falseLockThreshold,
    output demodPkg::sample_t avgFreq,
    output logic              highFreqOffset
);
    import demodPkg::*;

    sample_t                        freqScaled;    // Freq at top of sample
    sample_t                        alphaScaled;   // Alpha times 4
    sample_t                        oneMinusAlpha;
    logic signed [productWidth-1:0] prodFreq;
    logic signed [productWidth-1:0] prodAvg;
    logic signed [productWidth-1:0] prodSum;
    logic        [sampleWidth-1:0]  absAvg;

    assign freqScaled  = {freq, {detShift{1'b0}}};
    assign alphaScaled = {falseLockAlpha, 2'b00};
    assign oneMinusAlpha = alphaOne + ~alphaScaled; // Wraps modulo 2^18

    // Registered multipliers with one cycle of latency
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prodFreq <= '0;
            prodAvg  <= '0;
        end else begin
            prodFreq <= freqScaled * alphaScaled;  // New sample weight
            prodAvg  <= avgFreq * oneMinusAlpha;   // History weight
        end
    end

    assign prodSum = prodFreq + prodAvg;

    // Magnitude of the running average
    assign absAvg = avgFreq[sampleWidth-1] ? sampleWidth'(-avgFreq) : avgFreq;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            avgFreq        <= '0;
            highFreqOffset <= 1'b0;
        end else if (ddcSync) begin
            avgFreq <= prodSum[productWidth-2:sampleWidth-1]; // Bits 34:17
            // Flag uses the average from before this update
            highFreqOffset <= (absAvg > sampleWidth'(falseLockThreshold));
        end
    end

    // Products need a quiet cycle to catch up with the new average
    syncSpacing: assert property (@(posedge clk) disable iff (!arstN)
        ddcSync |=> !ddcSync);

endmodule

//--- src/symbolDeskew.sv
`timescale 1ns/1ps

module symbolDeskew (
    input  logic                 clk,
    input  logic                 arstN,
    input  demodPkg::iqStrobe_t  resamp,
    input  demodPkg::demodMode_t mode,
    output demodPkg::iqStrobe_t  sym
);
    import demodPkg::*;

    sample_t iSym;
    sample_t qSym;
    sample_t qDelay;                               // Q of previous strobe
    logic    symSync;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            symSync <= 1'b0;
        end else begin
            symSync <= resamp.sync;                // One cycle behind input
        end
    end

    always_ff @(posedge clk) begin
        if (resamp.sync) begin
            iSym   <= resamp.i;
            qDelay <= resamp.q;
            // Offset QPSK lags Q by half a symbol
            qSym   <= (mode == modeOqpsk) ? qDelay : resamp.q;
        end
    end

    assign sym = '{i: iSym, q: qSym, sync: symSync};

endmodule

//--- src/dacSelect.sv
`timescale 1ns/1ps

module dacSelect (
    input  logic                   clk,
    input  logic                   arstN,
    input  demodPkg::dacSource_t   sel,
    input  demodPkg::monitorTaps_t taps,
    output demodPkg::dacOut_t      dac
);
    import demodPkg::*;

    sample_t dataNext;
    logic    syncNext;

    always_comb begin
        case (sel)
            dacQ: begin
                dataNext = taps.ddc.q;
                syncNext = taps.ddc.sync;
            end
            dacISym: begin
                dataNext = taps.sym.i;
                syncNext = taps.sym.sync;          // Symbol rate
            end
            dacQSym: begin
                dataNext = taps.sym.q;
                syncNext = taps.sym.sync;          // Symbol rate
            end
            dacFreq: begin
                dataNext = {taps.det.freq, {detShift{1'b0}}};
                syncNext = taps.ddc.sync;
            end
            dacPhase: begin
                dataNext = {taps.det.phase, {detShift{1'b0}}};
                syncNext = taps.ddc.sync;
            end
            dacMag: begin
                // Offset binary to two's complement
                dataNext = {~taps.det.mag[magWidth-1], taps.det.mag[magWidth-2:0],
                            {magShift{1'b0}}};
                syncNext = taps.ddc.sync;
            end
            dacAvgFreq: begin
                dataNext = taps.avgFreq;
                syncNext = taps.ddc.sync;
            end
            default: begin                         // dacI and unused codes
                dataNext = taps.ddc.i;
                syncNext = taps.ddc.sync;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dac <= '0;
        end else begin
            dac <= '{data: dataNext, sync: syncNext};
        end
    end

    // Strobe stays defined whichever source is picked
    syncKnown: assert property (@(posedge clk) disable iff (!arstN)
        !$isunknown(dac.sync));

endmodule

//--- src/demodBackEnd.sv
`timescale 1ns/1ps

module demodBackEnd (
    input  logic                   clk,
    input  logic                   arstN,
    input  demodPkg::regAddr_t     addr,
    input  demodPkg::regData_t     din,
    input  demodPkg::byteWrite_t   wr,
    output demodPkg::regData_t     dout,
    input  demodPkg::iqStrobe_t    ddc,
    input  demodPkg::iqStrobe_t    resamp,
    input  demodPkg::detectorOut_t det,
    output demodPkg::iqStrobe_t    sym,
    output logic                   highFreqOffset,
    output demodPkg::dacOut_t      dac0,
    output demodPkg::dacOut_t      dac1,
    output demodPkg::dacOut_t      dac2
);
    import demodPkg::*;

    demodMode_t   mode;
    dacSource_t   dacSel [3];                      // One select per DAC
    coef_t        falseLockAlpha;
    coef_t        falseLockThreshold;
    sample_t      avgFreq;
    monitorTaps_t taps;

    // Sources shared by all monitor outputs
    assign taps = '{ddc: ddc, sym: sym, det: det, avgFreq: avgFreq};

    demodRegs i_demodRegs (
        .clk                (clk),
        .arstN              (arstN),
        .addr               (addr),
        .din                (din),
        .wr                 (wr),
        .dout               (dout),
        .highFreqOffset     (highFreqOffset),
        .mode               (mode),
        .dacSel             (dacSel),
        .falseLockAlpha     (falseLockAlpha),
        .falseLockThreshold (falseLockThreshold)
    );

    falseLockDetector i_falseLockDetector (
        .clk                (clk),
        .arstN              (arstN),
        .ddcSync            (ddc.sync),
        .freq               (det.freq),
        .falseLockAlpha     (falseLockAlpha),
        .falseLockThreshold (falseLockThreshold),
        .avgFreq            (avgFreq),
        .highFreqOffset     (highFreqOffset)
    );

    symbolDeskew i_symbolDeskew (
        .clk    (clk),
        .arstN  (arstN),
        .resamp (resamp),
        .mode   (mode),
        .sym    (sym)
    );

    dacSelect i_dacSelect0 (
        .clk   (clk),
        .arstN (arstN),
        .sel   (dacSel[0]),
        .taps  (taps),
        .dac   (dac0)
    );

    dacSelect i_dacSelect1 (
        .clk   (clk),
        .arstN (arstN),
        .sel   (dacSel[1]),
        .taps  (taps),
        .dac   (dac1)
    );

    dacSelect i_dacSelect2 (
        .clk   (clk),
        .arstN (arstN),
        .sel   (dacSel[2]),
        .taps  (taps),
        .dac   (dac2)
    );

endmodule

//--- test/demodBackEndTb.sv
`timescale 1ns/1ps

module demodBackEndTb;
    import demodPkg::*;

    localparam int waitLimit = 20;                 // Cycles before a wait gives up

    logic         clk = 1'b0;
    logic         arstN;
    regAddr_t     addr;
    regData_t     din;
    byteWrite_t   wr;
    regData_t     dout;
    iqStrobe_t    ddc;
    iqStrobe_t    resamp;
    detectorOut_t det;
    iqStrobe_t    sym;
    logic         highFreqOffset;
    dacOut_t      dac0;
    dacOut_t      dac1;
    dacOut_t      dac2;
    dacOut_t      dacOuts [3];

    int         errors = 0;
    bit         aborted = 1'b0;
    event       abortRun;
    dacSource_t selShadow [3];                     // Selects as last written
    coef_t      alphaShadow;
    coef_t      thresholdShadow;
    sample_t    modelAvg;                          // Expected running average
    sample_t    lastResampQ;                       // Q of previous resampler strobe

    assign dacOuts = '{dac0, dac1, dac2};

    always #4 clk = ~clk;                          // 8 ns period

    demodBackEnd i_dut (.*);

    function automatic regAddr_t demodAddr(input logic [3:0] offset);
        return {demodSpaceBase, offset};
    endfunction

    function automatic bit isSymSource(input dacSource_t sel);
        return (sel == dacISym) || (sel == dacQSym);
    endfunction

    // Scaled monitor value of a ddc-rate source
    function automatic sample_t expectedDac(input dacSource_t sel, input iqStrobe_t in,
                                            input detectorOut_t d, input sample_t avg);
        case (sel)
            dacQ:       return in.q;
            dacFreq:    return sample_t'(longint'(d.freq) * 1024);
            dacPhase:   return sample_t'(longint'(d.phase) * 1024);
            dacMag:     return sample_t'((longint'(d.mag) - 256) * 512); // Offset binary
            dacAvgFreq: return avg;
            default:    return in.i;                           // Undefined codes too
        endcase
    endfunction

    // Exponential average step in fixed point
    function automatic sample_t nextAverage(input sample_t old, input detector_t freq,
                                            input coef_t alpha);
        logic [17:0] alpha4;
        logic [17:0] weight;
        longint      sum;
        alpha4 = 18'(alpha) * 18'd4;
        weight = alphaOne + ~alpha4;               // Wraps modulo 2^18
        sum = longint'(freq) * 1024 * longint'(signed'(alpha4))
            + longint'(old) * longint'(signed'(weight));
        return sample_t'(sum >>> 17);              // Bits 34:17
    endfunction

    function automatic bit flagFromAverage(input sample_t avg, input coef_t threshold);
        longint magnitude;
        magnitude = (avg < 0) ? -longint'(avg) : longint'(avg);
        return magnitude > longint'(threshold);
    endfunction

    task automatic checkValue(input logic signed [63:0] actual,
                              input logic signed [63:0] expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout: no %s within %0d cycles at %0t", what, waitLimit, $time);
        errors++;
        aborted = 1'b1;
        -> abortRun;
    endtask

    // Waits for sym.sync or any DAC sync and counts the cycles
    task automatic waitForStrobe(input bit onSym, output int cycles);
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < waitLimit) begin
            @(negedge clk);
            ddc.sync    = 1'b0;                    // Input strobes last one cycle
            resamp.sync = 1'b0;
            cycles++;
            seen = onSym ? sym.sync : (dac0.sync | dac1.sync | dac2.sync);
        end
        if (!seen) begin
            reportTimeout(onSym ? "symbol strobe" : "DAC strobe");
        end
    endtask

    task automatic writeReg(input regAddr_t a, input regData_t data, input byteWrite_t lanes);
        @(negedge clk);
        addr = a;
        din  = data;
        wr   = lanes;
        @(negedge clk);
        wr = '0;
    endtask

    task automatic readReg(input regAddr_t a, output regData_t data);
        @(negedge clk);
        addr = a;
        #2;
        data = dout;                               // Readback has settled
    endtask

    task automatic setSelects(input dacSource_t a, input dacSource_t b, input dacSource_t c);
        writeReg(demodAddr(regDacSelect), {12'h0, c, 4'h0, b, 4'h0, a}, 4'b0111);
        selShadow = '{a, b, c};
    endtask

    task automatic setFalseLock(input coef_t alpha, input coef_t threshold);
        writeReg(demodAddr(regFalseLock), {threshold, alpha}, 4'b1111);
        alphaShadow     = alpha;
        thresholdShadow = threshold;
    endtask

    // One ddc strobe, checked on every ddc-rate DAC
    task automatic ddcStrobe(input detectorOut_t d);
        iqStrobe_t in;
        sample_t   oldAvg;
        bit        flagExp;
        int        n;
        in.i     = sample_t'($urandom);
        in.q     = sample_t'($urandom);
        in.sync  = 1'b1;
        oldAvg   = modelAvg;
        flagExp  = flagFromAverage(oldAvg, thresholdShadow);
        modelAvg = nextAverage(oldAvg, d.freq, alphaShadow);
        @(negedge clk);
        det = d;                                   // Settled ahead of the strobe
        @(negedge clk);
        ddc = in;
        waitForStrobe(1'b0, n);
        checkValue(n, 1, "ddc to DAC latency");
        checkValue(highFreqOffset, flagExp, "highFreqOffset");
        for (int k = 0; k < 3; k++) begin
            if (!isSymSource(selShadow[k])) begin
                checkValue(dacOuts[k].sync, 1'b1, $sformatf("dac%0d sync", k));
                checkValue(dacOuts[k].data, expectedDac(selShadow[k], in, d, oldAvg),
                           $sformatf("dac%0d data, select %0d", k, selShadow[k]));
            end
        end
        @(negedge clk);
        for (int k = 0; k < 3; k++) begin
            checkValue(dacOuts[k].sync, 1'b0, $sformatf("dac%0d sync low", k));
            if (selShadow[k] == dacAvgFreq) begin
                checkValue(dacOuts[k].data, modelAvg, $sformatf("dac%0d new average", k));
            end
        end
    endtask

    // One resampler strobe, checked on sym and symbol-rate DACs
    task automatic resampStrobe(input bit oqpsk);
        sample_t i;
        sample_t q;
        sample_t qExp;
        int      n;
        i    = sample_t'($urandom);
        q    = sample_t'($urandom);
        qExp = oqpsk ? lastResampQ : q;            // Offset Q lags one symbol
        @(negedge clk);
        resamp = '{i: i, q: q, sync: 1'b1};
        waitForStrobe(1'b1, n);
        checkValue(n, 1, "symbol strobe latency");
        checkValue(sym.i, i, "sym.i");
        checkValue(sym.q, qExp, "sym.q");
        waitForStrobe(1'b0, n);
        checkValue(n, 1, "symbol to DAC latency");
        for (int k = 0; k < 3; k++) begin
            if (isSymSource(selShadow[k])) begin
                checkValue(dacOuts[k].sync, 1'b1, $sformatf("dac%0d symbol sync", k));
                checkValue(dacOuts[k].data, (selShadow[k] == dacISym) ? i : qExp,
                           $sformatf("dac%0d symbol data", k));
            end else begin
                checkValue(dacOuts[k].sync, 1'b0, $sformatf("dac%0d sync on symbol", k));
            end
        end
        lastResampQ = q;
    endtask

    task automatic testRegisters();
        regData_t rd;
        for (int r = 0; r < 4; r++) begin
            readReg(demodAddr(4'(r)), rd);
            checkValue(rd, 32'h0, $sformatf("reset value of register %0d", r));
        end
        writeReg(demodAddr(regMode), 32'(modeBpsk), 4'b1110); // Lane 0 off
        readReg(demodAddr(regMode), rd);
        checkValue(rd, 32'h0, "mode without lane 0");
        writeReg(demodAddr(regMode), 32'(modeBpsk), 4'b0001);
        readReg(demodAddr(regMode), rd);
        checkValue(rd, 32'(modeBpsk), "mode");
        writeReg(demodAddr(regDacSelect), 32'h0006_0504, 4'b0101);
        readReg(demodAddr(regDacSelect), rd);
        checkValue(rd, 32'h0006_0004, "DAC select lanes 0 and 2");
        writeReg(demodAddr(regDacSelect), 32'h0006_0504, 4'b0010);
        readReg(demodAddr(regDacSelect), rd);
        checkValue(rd, 32'h0006_0504, "DAC select lane 1");
        writeReg(demodAddr(regFalseLock), 32'hA5A5_1234, 4'b0011);
        readReg(demodAddr(regFalseLock), rd);
        checkValue(rd, 32'h0000_1234, "false-lock alpha");
        writeReg(demodAddr(regFalseLock), 32'hBEEF_0000, 4'b1100);
        readReg(demodAddr(regFalseLock), rd);
        checkValue(rd, 32'hBEEF_1234, "false-lock threshold");
        writeReg({demodSpaceBase + 8'h1, regFalseLock}, 32'h0, 4'b1111); // Other space
        readReg(demodAddr(regFalseLock), rd);
        checkValue(rd, 32'hBEEF_1234, "false-lock after outside write");
        readReg({demodSpaceBase + 8'h1, regFalseLock}, rd);
        checkValue(rd, 32'h0, "readback outside demod space");
        writeReg(demodAddr(regMode), 32'(modeAm), 4'b0001);
        setSelects(dacI, dacI, dacI);
        setFalseLock('0, '0);
    endtask

    task automatic testDacSelect();
        dacSource_t sources [8] = '{dacI, dacQ, dacFreq, dacPhase, dacMag, dacAvgFreq,
                                    dacSource_t'(4'd7), dacSource_t'(4'd15)};
        for (int s = 0; s < 8; s++) begin
            setSelects(sources[s], sources[(s + 1) % 8], sources[(s + 2) % 8]);
            repeat (2) ddcStrobe(detectorOut_t'($urandom));
        end
    endtask

    task automatic testDeskew();
        setSelects(dacISym, dacQSym, dacI);
        writeReg(demodAddr(regMode), 32'(modeQpsk), 4'b0001);
        repeat (4) resampStrobe(1'b0);
        writeReg(demodAddr(regMode), 32'(modeOqpsk), 4'b0001);
        repeat (6) resampStrobe(1'b1);
    endtask

    task automatic testAverage();
        detectorOut_t d;
        setSelects(dacFreq, dacMag, dacAvgFreq);
        for (int round = 0; round < 3; round++) begin
            d = detectorOut_t'($urandom);          // Freq held for the whole round
            setFalseLock(coef_t'($urandom_range(16'h7FFF, 1)), 16'hFFFF);
            repeat (10) ddcStrobe(d);
        end
    endtask

    task automatic testHighOffset();
        regData_t     rd;
        detectorOut_t d;
        d      = detectorOut_t'($urandom);
        d.freq = 8'sd100;
        setFalseLock(16'h4000, 16'h2000);
        repeat (6) ddcStrobe(d);
        checkValue(highFreqOffset, 1'b1, "flag with large offset");
        readReg(demodAddr(regStatus), rd);
        checkValue(rd, 32'h1, "status with flag set");
        d.freq = '0;
        writeReg(demodAddr(regFalseLock), 32'hF000_0000, 4'b1100); // Threshold only
        thresholdShadow = 16'hF000;
        repeat (6) ddcStrobe(d);
        checkValue(highFreqOffset, 1'b0, "flag after offset removed");
        readReg(demodAddr(regStatus), rd);
        checkValue(rd, 32'h0, "status with flag clear");
    endtask

    task automatic runTests();
        testRegisters();
        testDacSelect();
        testDeskew();
        testAverage();
        testHighOffset();
    endtask

    initial begin
        arstN           = 1'b0;
        addr            = '0;
        din             = '0;
        wr              = '0;
        ddc             = '0;
        resamp          = '0;
        det             = '0;
        selShadow       = '{dacI, dacI, dacI};
        alphaShadow     = '0;
        thresholdShadow = '0;
        modelAvg        = '0;
        lastResampQ     = '0;
        void'($urandom(32'heff5dc85));
        repeat (8) @(negedge clk);
        arstN = 1'b1;
        fork
            runTests();
            @(abortRun);                           // A timed-out wait ends the run
        join_any
        $display("Run finished with %0d error(s)", errors);
        if (errors == 0 && !aborted) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- list.f
src/demodPkg.sv
src/demodRegs.sv
src/falseLockDetector.sv
src/symbolDeskew.sv
src/dacSelect.sv
src/demodBackEnd.sv
test/demodBackEndTb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module demodBackEndTb \
		-Mdir obj_dir -f list.f
	./obj_dir/VdemodBackEndTb | tee sim.log
	grep -qF "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log
